/* src/div_op_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide operation codes, operand widths and the
// request / response structs shared by every block
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package div_op_pkg;

    localparam int DATA_W  = 32;
    localparam int RADDR_W = 5;  // rd index

    typedef enum logic [3:0] {
        OP_DIV  = 4'b0001,
        OP_DIVU = 4'b0010,
        OP_REM  = 4'b0100,
        OP_REMU = 4'b1000
    } div_op_t;

    typedef struct packed {
        div_op_t            op;
        logic [DATA_W-1:0]  dividend;
        logic [DATA_W-1:0]  divisor;
        logic [RADDR_W-1:0] waddr;
    } div_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]  result;
        logic [RADDR_W-1:0] waddr;  // tag back to the core
    } div_rsp_t;

endpackage

/* src/div_cfg_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide unit configuration, lane count
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package div_cfg_pkg;

    // lanes run independently, one operation each
    localparam int NUM_LANES = 4;

    // width of a lane number
    localparam int LANE_IDX_W = $clog2(NUM_LANES);

endpackage

/* src/div_dispatch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request dispatcher, picks the lowest free lane and
// holds its start level and operands until ready
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_dispatch (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  logic                                                req_valid_i,
    input  div_op_pkg::div_req_t                                req_i,
    output logic                                                accept_o,
    input  logic                 [div_cfg_pkg::NUM_LANES-1:0]   lane_busy_i,
    input  logic                 [div_cfg_pkg::NUM_LANES-1:0]   lane_ready_i,
    input  logic                 [div_cfg_pkg::NUM_LANES-1:0]   slot_full_i,
    output logic                 [div_cfg_pkg::NUM_LANES-1:0]   lane_start_o,
    output div_op_pkg::div_req_t [div_cfg_pkg::NUM_LANES-1:0]   lane_req_o
);

    logic [div_cfg_pkg::NUM_LANES-1:0]  free;
    logic [div_cfg_pkg::LANE_IDX_W-1:0] pick;
    logic                               init_q;  // low for the first cycle out of reset
    logic                               take;

    // a lane with a pending result in its slot is not free yet
    assign free = ~lane_start_o & ~lane_busy_i & ~slot_full_i;

    // lowest index wins
    always_comb begin
        pick = '0;
        for (int i = div_cfg_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (free[i]) begin
                pick = i[div_cfg_pkg::LANE_IDX_W-1:0];
            end
        end
    end

    assign accept_o = init_q & (|free);
    assign take     = req_valid_i & accept_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            init_q       <= 1'b0;
            lane_start_o <= '0;
        end else begin
            init_q <= 1'b1;
            for (int i = 0; i < div_cfg_pkg::NUM_LANES; i++) begin
                if (lane_ready_i[i]) begin
                    lane_start_o[i] <= 1'b0;  // lane done, release it
                end
            end
            if (take) begin
                lane_start_o[pick] <= 1'b1;
            end
        end
    end

    // operands stay put while the lane works on them
    always_ff @(posedge clk) begin
        if (take) begin
            lane_req_o[pick] <= req_i;
        end
    end

    a_one_start: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(lane_start_o & ~$past(lane_start_o)));

endmodule

/* src/div_lane.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one divide lane, 32-bit restoring divider with
// RISC-V sign and divide-by-zero handling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_lane (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  div_op_pkg::div_req_t req_i,
    output logic                 busy_o,
    output logic                 ready_o,
    output div_op_pkg::div_rsp_t rsp_o
);

    typedef enum logic [3:0] {
        S_IDLE  = 4'b0001,
        S_START = 4'b0010,
        S_CALC  = 4'b0100,
        S_END   = 4'b1000
    } state_t;

    state_t                                   state_q;
    div_op_pkg::div_op_t                      op_q;
    logic [div_op_pkg::DATA_W-1:0]            dvd_q;    // dividend, shifted out msb first
    logic [div_op_pkg::DATA_W-1:0]            dvs_q;    // divisor
    logic [div_op_pkg::DATA_W-1:0]            rem_q;    // partial remainder
    logic [div_op_pkg::DATA_W-1:0]            quo_q;
    logic [div_op_pkg::RADDR_W-1:0]           waddr_q;
    logic                                     inv_q;    // negate the final result
    logic [$clog2(div_op_pkg::DATA_W)-1:0]    cnt_q;

    logic                                     is_signed;
    logic                                     want_quo;
    logic [div_op_pkg::DATA_W-1:0]            dvd_abs;
    logic [div_op_pkg::DATA_W-1:0]            dvs_abs;
    logic [div_op_pkg::DATA_W:0]              shifted;
    logic [div_op_pkg::DATA_W:0]              diff;
    logic                                     ge;
    logic [div_op_pkg::DATA_W-1:0]            res_raw;
    logic [div_op_pkg::DATA_W-1:0]            res_fix;

    // one-hot decode
    assign is_signed = |(op_q & (div_op_pkg::OP_DIV | div_op_pkg::OP_REM));
    assign want_quo  = |(op_q & (div_op_pkg::OP_DIV | div_op_pkg::OP_DIVU));

    assign dvd_abs = (is_signed && dvd_q[div_op_pkg::DATA_W-1]) ? -dvd_q : dvd_q;
    assign dvs_abs = (is_signed && dvs_q[div_op_pkg::DATA_W-1]) ? -dvs_q : dvs_q;

    // trial subtraction, one extra bit so a large divisor cannot overflow
    assign shifted = {rem_q, dvd_q[div_op_pkg::DATA_W-1]};
    assign diff    = shifted - {1'b0, dvs_q};
    assign ge      = ~diff[div_op_pkg::DATA_W];

    assign res_raw = want_quo ? quo_q : rem_q;
    assign res_fix = inv_q ? -res_raw : res_raw;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            busy_o  <= 1'b0;
            ready_o <= 1'b0;
        end else begin
            ready_o <= 1'b0;
            if (state_q != S_IDLE && !start_i) begin
                state_q <= S_IDLE;  // start dropped, abort quietly
                busy_o  <= 1'b0;
            end else begin
                case (state_q)
                    S_IDLE: begin
                        // start is still high in the cycle of our own ready pulse
                        if (start_i && !ready_o) begin
                            op_q    <= req_i.op;
                            dvd_q   <= req_i.dividend;
                            dvs_q   <= req_i.divisor;
                            waddr_q <= req_i.waddr;
                            busy_o  <= 1'b1;
                            state_q <= S_START;
                        end
                    end
                    S_START: begin
                        if (dvs_q == '0) begin
                            quo_q   <= '1;     // x/0 = all ones
                            rem_q   <= dvd_q;  // x%0 = x
                            inv_q   <= 1'b0;
                            state_q <= S_END;
                        end else begin
                            dvd_q   <= dvd_abs;
                            dvs_q   <= dvs_abs;
                            rem_q   <= '0;
                            quo_q   <= '0;
                            cnt_q   <= '0;
                            // quotient sign from both operands, remainder follows the dividend
                            if (want_quo) begin
                                inv_q <= is_signed & (dvd_q[div_op_pkg::DATA_W-1]
                                                      ^ dvs_q[div_op_pkg::DATA_W-1]);
                            end else begin
                                inv_q <= is_signed & dvd_q[div_op_pkg::DATA_W-1];
                            end
                            state_q <= S_CALC;
                        end
                    end
                    S_CALC: begin
                        dvd_q <= dvd_q << 1;
                        rem_q <= ge ? diff[div_op_pkg::DATA_W-1:0]
                                    : shifted[div_op_pkg::DATA_W-1:0];
                        quo_q <= {quo_q[div_op_pkg::DATA_W-2:0], ge};
                        cnt_q <= cnt_q + 1'b1;
                        if (&cnt_q) begin
                            state_q <= S_END;  // last quotient bit
                        end
                    end
                    S_END: begin
                        rsp_o.result <= res_fix;
                        rsp_o.waddr  <= waddr_q;
                        ready_o      <= 1'b1;
                        busy_o       <= 1'b0;
                        state_q      <= S_IDLE;
                    end
                    default: begin
                        state_q <= S_IDLE;
                        busy_o  <= 1'b0;
                    end
                endcase
            end
        end
    end

    a_ready_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |-> !busy_o);

    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |=> !ready_o);

endmodule

/* src/div_collect.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result collector, one slot per lane drained to a
// single response port in fixed priority
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_collect (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    input  logic                 [div_cfg_pkg::NUM_LANES-1:0]   lane_ready_i,
    input  div_op_pkg::div_rsp_t [div_cfg_pkg::NUM_LANES-1:0]   lane_rsp_i,
    output logic                 [div_cfg_pkg::NUM_LANES-1:0]   slot_full_o,
    output logic                                                rsp_valid_o,
    output div_op_pkg::div_rsp_t                                rsp_o
);

    div_op_pkg::div_rsp_t [div_cfg_pkg::NUM_LANES-1:0] slot_q;
    logic [div_cfg_pkg::LANE_IDX_W-1:0]                 sel;  // slot leaving this cycle

    // lowest full slot goes first
    always_comb begin
        sel = '0;
        for (int i = div_cfg_pkg::NUM_LANES - 1; i >= 0; i--) begin
            if (slot_full_o[i]) begin
                sel = i[div_cfg_pkg::LANE_IDX_W-1:0];
            end
        end
    end

    assign rsp_valid_o = |slot_full_o;
    assign rsp_o       = slot_q[sel];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            slot_full_o <= '0;
        end else begin
            for (int i = 0; i < div_cfg_pkg::NUM_LANES; i++) begin
                if (lane_ready_i[i]) begin
                    slot_full_o[i] <= 1'b1;
                end else if (rsp_valid_o && sel == i) begin
                    slot_full_o[i] <= 1'b0;  // drained
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < div_cfg_pkg::NUM_LANES; i++) begin
            if (lane_ready_i[i]) begin
                slot_q[i] <= lane_rsp_i[i];
            end
        end
    end

    // dispatcher must keep a lane idle until its slot is drained
    a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n_i)
        (lane_ready_i & slot_full_o) == '0);

endmodule

/* src/div_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// multi-lane divide unit top, dispatcher + lanes +
// collector
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module div_unit (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  div_op_pkg::div_req_t req_i,
    output logic                 accept_o,
    output logic                 rsp_valid_o,
    output div_op_pkg::div_rsp_t rsp_o
);

    logic                 [div_cfg_pkg::NUM_LANES-1:0] lane_start;
    logic                 [div_cfg_pkg::NUM_LANES-1:0] lane_busy;
    logic                 [div_cfg_pkg::NUM_LANES-1:0] lane_ready;
    logic                 [div_cfg_pkg::NUM_LANES-1:0] slot_full;
    div_op_pkg::div_req_t [div_cfg_pkg::NUM_LANES-1:0] lane_req;
    div_op_pkg::div_rsp_t [div_cfg_pkg::NUM_LANES-1:0] lane_rsp;

    div_dispatch u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .accept_o     (accept_o),
        .lane_busy_i  (lane_busy),
        .lane_ready_i (lane_ready),
        .slot_full_i  (slot_full),
        .lane_start_o (lane_start),
        .lane_req_o   (lane_req)
    );

    for (genvar g = 0; g < div_cfg_pkg::NUM_LANES; g++) begin : g_lane
        div_lane u_lane (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .start_i (lane_start[g]),
            .req_i   (lane_req[g]),
            .busy_o  (lane_busy[g]),
            .ready_o (lane_ready[g]),
            .rsp_o   (lane_rsp[g])
        );
    end

    div_collect u_collect (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .lane_ready_i (lane_ready),
        .lane_rsp_i   (lane_rsp),
        .slot_full_o  (slot_full),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_o        (rsp_o)
    );

endmodule

/* testbench/tb_div_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// divide unit testbench, directed and random tests
// checked by tag against a RISC-V result model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_div_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ACCEPT_LIMIT = 200;  // cycles
    localparam int IDLE_LIMIT   = 400;

    logic                 clk = 1'b0;
    logic                 rst_n_i;
    logic                 req_valid_i;
    div_op_pkg::div_req_t req_i;
    logic                 accept_o;
    logic                 rsp_valid_o;
    div_op_pkg::div_rsp_t rsp_o;

    logic        pending [32];     // tag outstanding
    logic [31:0] expect_val [32];  // model result per tag
    int          n_pending;
    int          n_sent;
    integer      seed;

    div_unit UUT (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .accept_o    (accept_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    // RISC-V M extension semantics
    function automatic logic [31:0] riscv_result(input div_op_pkg::div_op_t op,
                                                 input logic [31:0] a, input logic [31:0] b);
        logic ovf;
        ovf = (a == 32'h8000_0000) && (b == 32'hFFFF_FFFF);
        riscv_result = '0;
        if (op == div_op_pkg::OP_DIVU) begin
            if (b == '0) riscv_result = 32'hFFFF_FFFF;
            else riscv_result = a / b;
        end else if (op == div_op_pkg::OP_REMU) begin
            if (b == '0) riscv_result = a;
            else riscv_result = a % b;
        end else if (op == div_op_pkg::OP_DIV) begin
            if (b == '0) riscv_result = 32'hFFFF_FFFF;
            else if (ovf) riscv_result = 32'h8000_0000;
            else riscv_result = $signed(a) / $signed(b);  // truncates toward zero
        end else begin
            if (b == '0) riscv_result = a;
            else if (ovf) riscv_result = '0;
            else riscv_result = $signed(a) % $signed(b);  // sign of dividend
        end
    endfunction

    function automatic div_op_pkg::div_op_t op_from_index(input logic [1:0] idx);
        case (idx)
            2'd0:    op_from_index = div_op_pkg::OP_DIV;
            2'd1:    op_from_index = div_op_pkg::OP_DIVU;
            2'd2:    op_from_index = div_op_pkg::OP_REM;
            default: op_from_index = div_op_pkg::OP_REMU;
        endcase
    endfunction

    // called 1 ns after a rising edge, returns at the same phase
    task automatic send(input div_op_pkg::div_op_t op, input logic [31:0] a,
                        input logic [31:0] b, input logic [4:0] tag_hint);
        logic [4:0] tag;
        int         waited;
        tag    = tag_hint;
        waited = 0;
        while (pending[tag]) tag = tag + 1'b1;  // at most four tags in flight
        while (!accept_o) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ACCEPT_LIMIT) abort_run("timed out waiting for accept");
        end
        pending[tag]    = 1'b1;
        expect_val[tag] = riscv_result(op, a, b);
        n_pending++;
        n_sent++;
        req_i.op       = op;
        req_i.dividend = a;
        req_i.divisor  = b;
        req_i.waddr    = tag;
        req_valid_i    = 1'b1;
        @(posedge clk);
        #1;
        req_valid_i = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (n_pending != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > IDLE_LIMIT) abort_run("timed out waiting for responses");
        end
    endtask

    task automatic check_response(input div_op_pkg::div_rsp_t rsp);
        logic [4:0] tag;
        tag = rsp.waddr;
        assert (pending[tag]) else
            abort_run($sformatf("response arrived for tag %0d which was not outstanding", tag));
        assert (rsp.result === expect_val[tag]) else
            abort_run($sformatf("[FAIL] %0t: tag %0d result %08h, expected %08h",
                                $time, tag, rsp.result, expect_val[tag]));
        pending[tag] = 1'b0;
        n_pending--;
    endtask

    // responses sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n_i && rsp_valid_o) begin
            check_response(rsp_o);
        end
    end

    task automatic unsigned_ops();
        send(div_op_pkg::OP_DIVU, 32'd100, 32'd7, n_sent[4:0]);
        send(div_op_pkg::OP_REMU, 32'd100, 32'd7, n_sent[4:0]);
        send(div_op_pkg::OP_DIVU, 32'hFFFF_FFFF, 32'd3, n_sent[4:0]);
        send(div_op_pkg::OP_REMU, 32'hFFFF_FFFF, 32'd3, n_sent[4:0]);
        send(div_op_pkg::OP_DIVU, 32'd7, 32'd100, n_sent[4:0]);
        send(div_op_pkg::OP_REMU, 32'h8000_0005, 32'h8000_0000, n_sent[4:0]);
        wait_idle();
    endtask

    task automatic signed_ops();
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < 4; i++) begin
            a = i[0] ? 32'hFFFF_FFEC : 32'd20;  // -20 or 20
            b = i[1] ? 32'hFFFF_FFFA : 32'd6;   // -6 or 6
            send(div_op_pkg::OP_DIV, a, b, n_sent[4:0]);
            send(div_op_pkg::OP_REM, a, b, n_sent[4:0]);
        end
        // overflow case
        send(div_op_pkg::OP_DIV, 32'h8000_0000, 32'hFFFF_FFFF, n_sent[4:0]);
        send(div_op_pkg::OP_REM, 32'h8000_0000, 32'hFFFF_FFFF, n_sent[4:0]);
        wait_idle();
    endtask

    task automatic zero_divisor_ops();
        send(div_op_pkg::OP_DIV, 32'h1234_5678, 32'd0, n_sent[4:0]);
        send(div_op_pkg::OP_DIVU, 32'h1234_5678, 32'd0, n_sent[4:0]);
        send(div_op_pkg::OP_REM, 32'hDEAD_BEEF, 32'd0, n_sent[4:0]);
        send(div_op_pkg::OP_REMU, 32'hDEAD_BEEF, 32'd0, n_sent[4:0]);
        wait_idle();
    endtask

    task automatic all_lanes_busy();
        time t0;
        t0 = $time;
        send(div_op_pkg::OP_DIVU, 32'd1000, 32'd9, 5'd4);
        send(div_op_pkg::OP_DIV, 32'hFFFF_FC18, 32'd7, 5'd9);
        send(div_op_pkg::OP_REM, 32'd12345, 32'hFFFF_FFF5, 5'd17);
        send(div_op_pkg::OP_REMU, 32'hCAFE_F00D, 32'd251, 5'd30);
        assert ($time - t0 == 32) else
            abort_run($sformatf("[FAIL] %0t: four requests were not taken back to back", $time));
        assert (accept_o === 1'b0) else
            abort_run($sformatf("[FAIL] %0t: accept_o high with all lanes busy", $time));
        send(div_op_pkg::OP_DIVU, 32'd77, 32'd11, 5'd22);  // held until a lane frees up
        wait_idle();
    endtask

    task automatic random_ops();
        logic [31:0]         r;
        logic [31:0]         a;
        logic [31:0]         b;
        div_op_pkg::div_op_t op;
        for (int n = 0; n < 64; n++) begin
            r  = $random(seed);
            a  = $random(seed);
            b  = $random(seed);
            op = op_from_index(r[1:0]);
            if (r[4:2] == 3'd0) begin
                b = '0;  // zero divisor now and then
            end else if (r[4:2] == 3'd1) begin
                b = {24'd0, b[7:0]};
            end
            send(op, a, b, r[20:16]);
        end
        wait_idle();
    endtask

    initial begin
        seed        = 63;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        n_pending   = 0;
        n_sent      = 0;
        for (int i = 0; i < 32; i++) begin
            pending[i]    = 1'b0;
            expect_val[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        unsigned_ops();
        signed_ops();
        zero_divisor_ops();
        all_lanes_busy();
        random_ops();

        $display("Done: no errors");
        $finish;
    end

endmodule

/* all.f */
src/div_op_pkg.sv
src/div_cfg_pkg.sv
src/div_dispatch.sv
src/div_lane.sv
src/div_collect.sv
src/div_unit.sv
testbench/tb_div_unit.sv

/* Makefile */
# Verilator build and run of the divide unit testbench
TOP := tb_div_unit

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wno-fatal -Mdir obj_dir \
		--top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
